//--- Makefile
# Verilator flow for the dcache testbench

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module dcache_tb -f dcache_top.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module dcache_tb -f dcache_top.f
	./obj_dir/Vdcache_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Checks failed" sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dcache_top.f
logic/dcache_pkg.sv
logic/dcache_way_if.sv
logic/dcache_way.sv
logic/dcache_way_select.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
sim/dcache_asserts.sv
sim/dcache_tb.sv

//--- logic/dcache_ctrl.sv
//##########################################################################
// dcache controller
// one request at a time: lookup, writeback, refill and response
//##########################################################################

`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                req_valid_i,
    output logic                                req_ready_o,
    input  logic                                req_write_i,
    input  logic [dcache_pkg::ADDR_W-1:0]       req_addr_i,
    input  logic [dcache_pkg::DATA_W-1:0]       req_wdata_i,
    input  logic [dcache_pkg::STRB_W-1:0]       req_strb_i,
    output logic                                rsp_valid_o,
    input  logic                                rsp_ready_i,
    output logic [dcache_pkg::DATA_W-1:0]       rsp_rdata_o,
    output logic                                mem_req_valid_o,
    input  logic                                mem_req_ready_i,
    output logic                                mem_req_write_o,
    output logic [dcache_pkg::ADDR_W-1:0]       mem_req_addr_o,
    output logic [dcache_pkg::DATA_W-1:0]       mem_req_wdata_o,
    input  logic                                mem_rsp_valid_i,
    input  logic [dcache_pkg::DATA_W-1:0]       mem_rsp_rdata_i,
    dcache_way_if.ctrl                          ways [dcache_pkg::NUM_WAYS],
    input  logic                                hit_i,
    input  logic                                hit_way_i,
    input  logic [dcache_pkg::DATA_W-1:0]       rdata_i,
    input  logic                                victim_way_i,
    input  logic                                victim_dirty_i,
    input  logic [dcache_pkg::TAG_W-1:0]        victim_tag_i,
    output logic                                access_o
);

    dcache_pkg::ctrl_state_t       state_q;
    dcache_pkg::ctrl_state_t       state_d;
    dcache_pkg::addr_t             req_q;
    logic                          req_write_q;
    logic [dcache_pkg::DATA_W-1:0] req_wdata_q;
    logic [dcache_pkg::STRB_W-1:0] req_strb_q;
    logic [dcache_pkg::DATA_W-1:0] rsp_rdata_q;
    logic                          victim_way_q;
    logic                          mem_write_q;
    logic [dcache_pkg::ADDR_W-1:0] mem_addr_q;
    logic [dcache_pkg::DATA_W-1:0] mem_wdata_q;
    logic [dcache_pkg::DATA_W-1:0] merged;
    logic [dcache_pkg::ADDR_W-1:0] line_addr;
    logic                          store_hit;
    logic                          fill_en;

    assign line_addr = {req_q.fields.tag, req_q.fields.index, {dcache_pkg::OFFSET_W{1'b0}}};
    assign store_hit = (state_q == dcache_pkg::COMPARE) && hit_i && req_write_q;
    assign fill_en   = (state_q == dcache_pkg::REFILL_WAIT) && mem_rsp_valid_i;
    assign access_o  = (state_q == dcache_pkg::COMPARE) && hit_i;

    // store bytes over the line read from the hit way
    always_comb begin
        for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
            merged[b*8 +: 8] = req_strb_q[b] ? req_wdata_q[b*8 +: 8] : rdata_i[b*8 +: 8];
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE: if (req_valid_i) state_d = dcache_pkg::LOOKUP;
            dcache_pkg::LOOKUP: state_d = dcache_pkg::COMPARE;
            dcache_pkg::COMPARE: begin
                if (hit_i) begin
                    state_d = dcache_pkg::RESPOND;
                end else if (victim_dirty_i) begin
                    state_d = dcache_pkg::WRITEBACK;
                end else begin
                    state_d = dcache_pkg::REFILL_REQ;
                end
            end
            dcache_pkg::WRITEBACK: if (mem_req_ready_i) state_d = dcache_pkg::REFILL_REQ;
            dcache_pkg::REFILL_REQ: if (mem_req_ready_i) state_d = dcache_pkg::REFILL_WAIT;
            // refilled line is looked up again
            dcache_pkg::REFILL_WAIT: if (mem_rsp_valid_i) state_d = dcache_pkg::LOOKUP;
            dcache_pkg::RESPOND: if (rsp_ready_i) state_d = dcache_pkg::IDLE;
            default: state_d = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= dcache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            req_q.raw   <= req_addr_i;
            req_write_q <= req_write_i;
            req_wdata_q <= req_wdata_i;
            req_strb_q  <= req_strb_i;
        end
        if (state_q == dcache_pkg::COMPARE) begin
            if (hit_i) begin
                rsp_rdata_q <= req_write_q ? merged : rdata_i;
            end else begin
                // no hit, so rdata_i carries the victim line
                victim_way_q <= victim_way_i;
                mem_write_q  <= victim_dirty_i;
                mem_addr_q   <= victim_dirty_i ?
                    {victim_tag_i, req_q.fields.index, {dcache_pkg::OFFSET_W{1'b0}}} : line_addr;
                mem_wdata_q  <= rdata_i;
            end
        end
        if ((state_q == dcache_pkg::WRITEBACK) && mem_req_ready_i) begin
            mem_write_q <= 1'b0;
            mem_addr_q  <= line_addr;
        end
    end

    for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++) begin : g_drive
        assign ways[w].index     = req_q.fields.index;
        assign ways[w].tag       = req_q.fields.tag;
        assign ways[w].wr_en     = store_hit && (hit_way_i == 1'(w));
        assign ways[w].set_dirty = store_hit && (hit_way_i == 1'(w));
        assign ways[w].strb      = req_strb_q;
        assign ways[w].wdata     = fill_en ? mem_rsp_rdata_i : merged;
        assign ways[w].fill      = fill_en && (victim_way_q == 1'(w));
    end

    assign req_ready_o     = (state_q == dcache_pkg::IDLE);
    assign rsp_valid_o     = (state_q == dcache_pkg::RESPOND);
    assign rsp_rdata_o     = rsp_rdata_q;
    assign mem_req_valid_o = (state_q == dcache_pkg::WRITEBACK) ||
                             (state_q == dcache_pkg::REFILL_REQ);
    assign mem_req_write_o = mem_write_q;
    assign mem_req_addr_o  = mem_addr_q;
    assign mem_req_wdata_o = mem_wdata_q;

endmodule

//--- logic/dcache_pkg.sv
//##########################################################################
// dcache shared definitions
// address widths, the decoded address view and controller states
//##########################################################################

package dcache_pkg;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 64;
    localparam int STRB_W   = 8;
    localparam int OFFSET_W = 3;
    localparam int SET_W    = 6;
    localparam int NUM_SETS = 64;
    localparam int TAG_W    = ADDR_W - SET_W - OFFSET_W;
    localparam int NUM_WAYS = 2;

    // field view of a byte address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [SET_W-1:0]    index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        addr_fields_t      fields;
    } addr_t;

    typedef enum logic [2:0] {
        IDLE, LOOKUP, COMPARE, WRITEBACK, REFILL_REQ, REFILL_WAIT, RESPOND
    } ctrl_state_t;

endpackage

//--- logic/dcache_top.sv
//##########################################################################
// dcache top
// two-way write-back data cache with processor and memory handshakes
//##########################################################################

`timescale 1ns/1ps

module dcache_top (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          req_valid_i,
    output logic                          req_ready_o,
    input  logic                          req_write_i,
    input  logic [dcache_pkg::ADDR_W-1:0] req_addr_i,
    input  logic [dcache_pkg::DATA_W-1:0] req_wdata_i,
    input  logic [dcache_pkg::STRB_W-1:0] req_strb_i,
    output logic                          rsp_valid_o,
    input  logic                          rsp_ready_i,
    output logic [dcache_pkg::DATA_W-1:0] rsp_rdata_o,
    output logic                          mem_req_valid_o,
    input  logic                          mem_req_ready_i,
    output logic                          mem_req_write_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_req_addr_o,
    output logic [dcache_pkg::DATA_W-1:0] mem_req_wdata_o,
    input  logic                          mem_rsp_valid_i,
    input  logic [dcache_pkg::DATA_W-1:0] mem_rsp_rdata_i
);

    logic                          hit;
    logic                          hit_way;
    logic [dcache_pkg::DATA_W-1:0] rdata;
    logic                          victim_way;
    logic                          victim_dirty;
    logic [dcache_pkg::TAG_W-1:0]  victim_tag;
    logic                          access;

    dcache_way_if way_bus [dcache_pkg::NUM_WAYS] ();

    dcache_ctrl u_ctrl (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_write_i     (req_write_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .req_strb_i      (req_strb_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .rsp_rdata_o     (rsp_rdata_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_write_o (mem_req_write_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_wdata_o (mem_req_wdata_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_rdata_i (mem_rsp_rdata_i),
        .ways            (way_bus),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .rdata_i         (rdata),
        .victim_way_i    (victim_way),
        .victim_dirty_i  (victim_dirty),
        .victim_tag_i    (victim_tag),
        .access_o        (access)
    );

    for (genvar g = 0; g < dcache_pkg::NUM_WAYS; g++) begin : g_way
        dcache_way u_way (
            .clk      (clk),
            .rst_n_i  (rst_n_i),
            .port_way (way_bus[g])
        );
    end

    dcache_way_select u_sel (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .ways           (way_bus),
        .access_i       (access),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .rdata_o        (rdata),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

endmodule

//--- logic/dcache_way.sv
//##########################################################################
// dcache way
// valid, dirty, tag and data arrays with a registered read and hit compare
//##########################################################################

`timescale 1ns/1ps

module dcache_way (
    input  logic      clk,
    input  logic      rst_n_i,
    dcache_way_if.way port_way
);

    logic                          valid_q [dcache_pkg::NUM_SETS];
    logic                          dirty_q [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::TAG_W-1:0]  tag_mem [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::DATA_W-1:0] data_mem [dcache_pkg::NUM_SETS];

    logic                          rd_valid_q;
    logic                          rd_dirty_q;
    logic [dcache_pkg::TAG_W-1:0]  rd_tag_q;
    logic [dcache_pkg::DATA_W-1:0] rd_data_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
                valid_q[s] <= 1'b0;
                dirty_q[s] <= 1'b0;
            end
        end else if (port_way.fill) begin
            valid_q[port_way.index] <= 1'b1;
            dirty_q[port_way.index] <= 1'b0;
        end else if (port_way.set_dirty) begin
            dirty_q[port_way.index] <= 1'b1;
        end
    end

    // fill takes the whole line, a store only its strobed bytes
    always_ff @(posedge clk) begin
        if (port_way.fill) begin
            tag_mem[port_way.index]  <= port_way.tag;
            data_mem[port_way.index] <= port_way.wdata;
        end else if (port_way.wr_en) begin
            for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
                if (port_way.strb[b]) begin
                    data_mem[port_way.index][b*8 +: 8] <= port_way.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_valid_q <= valid_q[port_way.index];
        rd_dirty_q <= dirty_q[port_way.index];
        rd_tag_q   <= tag_mem[port_way.index];
        rd_data_q  <= data_mem[port_way.index];
    end

    assign port_way.hit    = rd_valid_q && (rd_tag_q == port_way.tag);
    assign port_way.valid  = rd_valid_q;
    assign port_way.dirty  = rd_dirty_q;
    assign port_way.rd_tag = rd_tag_q;
    assign port_way.rdata  = rd_data_q;

endmodule

//--- logic/dcache_way_if.sv
//##########################################################################
// dcache way bus
// controller drives lookup and writes, the way returns its registered read
//##########################################################################

`timescale 1ns/1ps

interface dcache_way_if;

    // controller side
    logic [dcache_pkg::SET_W-1:0]  index;
    logic [dcache_pkg::TAG_W-1:0]  tag;
    logic                          wr_en;
    logic [dcache_pkg::STRB_W-1:0] strb;
    logic [dcache_pkg::DATA_W-1:0] wdata;
    logic                          set_dirty;
    logic                          fill;

    // way side lags the index by one cycle
    logic                          hit;
    logic                          valid;
    logic                          dirty;
    logic [dcache_pkg::TAG_W-1:0]  rd_tag;
    logic [dcache_pkg::DATA_W-1:0] rdata;

    modport ctrl (output index, tag, wr_en, strb, wdata, set_dirty, fill);
    modport way  (input index, tag, wr_en, strb, wdata, set_dirty, fill,
                  output hit, valid, dirty, rd_tag, rdata);
    modport sel  (input index, hit, valid, dirty, rd_tag, rdata);

endinterface

//--- logic/dcache_way_select.sv
//##########################################################################
// dcache way selector
// merges the way hits, keeps the per-set LRU bit and picks the victim
//##########################################################################

`timescale 1ns/1ps

module dcache_way_select (
    input  logic                          clk,
    input  logic                          rst_n_i,
    dcache_way_if.sel                     ways [dcache_pkg::NUM_WAYS],
    input  logic                          access_i,
    output logic                          hit_o,
    output logic                          hit_way_o,
    output logic [dcache_pkg::DATA_W-1:0] rdata_o,
    output logic                          victim_way_o,
    output logic                          victim_dirty_o,
    output logic [dcache_pkg::TAG_W-1:0]  victim_tag_o
);

    logic [dcache_pkg::NUM_WAYS-1:0] hit_vec;
    logic [dcache_pkg::NUM_WAYS-1:0] valid_vec;
    logic [dcache_pkg::NUM_WAYS-1:0] dirty_vec;
    logic [dcache_pkg::TAG_W-1:0]    tag_arr [dcache_pkg::NUM_WAYS];
    logic [dcache_pkg::DATA_W-1:0]   data_arr [dcache_pkg::NUM_WAYS];
    logic [dcache_pkg::NUM_SETS-1:0] lru_q;
    logic [dcache_pkg::SET_W-1:0]    set_idx;

    for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++) begin : g_collect
        assign hit_vec[w]   = ways[w].hit;
        assign valid_vec[w] = ways[w].valid;
        assign dirty_vec[w] = ways[w].dirty;
        assign tag_arr[w]   = ways[w].rd_tag;
        assign data_arr[w]  = ways[w].rdata;
    end

    // all ways see the same index
    assign set_idx   = ways[0].index;
    assign hit_o     = |hit_vec;
    assign hit_way_o = hit_vec[1];

    // empty way first, else the one not used last
    always_comb begin
        if (!valid_vec[0]) begin
            victim_way_o = 1'b0;
        end else if (!valid_vec[1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = lru_q[set_idx];
        end
    end

    assign victim_dirty_o = dirty_vec[victim_way_o];
    assign victim_tag_o   = tag_arr[victim_way_o];
    assign rdata_o        = hit_o ? data_arr[hit_way_o] : data_arr[victim_way_o];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            lru_q <= '0;
        end else if (access_i) begin
            lru_q[set_idx] <= ~hit_way_o;
        end
    end

endmodule

//--- sim/dcache_asserts.sv
//##########################################################################
// dcache handshake assertions
// response and memory request stability, reset state
//##########################################################################

`timescale 1ns/1ps

module dcache_asserts (
    input logic        clk,
    input logic        rst_n_i,
    input logic        req_ready_i,
    input logic        rsp_valid_i,
    input logic        rsp_ready_i,
    input logic [63:0] rsp_rdata_i,
    input logic        mem_valid_i,
    input logic        mem_ready_i,
    input logic        mem_write_i,
    input logic [31:0] mem_addr_i,
    input logic [63:0] mem_wdata_i
);

    property rsp_held;
        @(posedge clk) disable iff (!rst_n_i)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_rdata_i);
    endproperty

    property mem_req_held;
        @(posedge clk) disable iff (!rst_n_i)
        mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_write_i) &&
            $stable(mem_addr_i) && $stable(mem_wdata_i);
    endproperty

    property no_accept_while_responding;
        @(posedge clk) disable iff (!rst_n_i)
        rsp_valid_i |-> !req_ready_i;
    endproperty

    // state right after a reset edge
    property reset_quiet;
        @(posedge clk)
        !rst_n_i |=> !rsp_valid_i && !mem_valid_i && req_ready_i;
    endproperty

    a_rsp_held: assert property (rsp_held)
        else $error("response dropped or changed before rsp_ready_i");
    a_mem_req_held: assert property (mem_req_held)
        else $error("memory request dropped or changed before mem_req_ready_i");
    a_no_accept: assert property (no_accept_while_responding)
        else $error("req_ready_o high while a response is pending");
    a_reset_quiet: assert property (reset_quiet)
        else $error("control outputs active after a reset edge");

endmodule

bind dcache_top dcache_asserts u_asserts (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_ready_i (req_ready_o),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_i (rsp_rdata_o),
    .mem_valid_i (mem_req_valid_o),
    .mem_ready_i (mem_req_ready_i),
    .mem_write_i (mem_req_write_o),
    .mem_addr_i  (mem_req_addr_o),
    .mem_wdata_i (mem_req_wdata_o)
);

//--- sim/dcache_tb.sv
//##########################################################################
// dcache testbench
// file-driven loads and stores against a memory model with random stalls
//##########################################################################

`timescale 1ns/1ps

module dcache_tb;

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [63:0] wdata;
        logic [7:0]  strb;
        logic [63:0] exp_rdata;
        logic [3:0]  exp_rd;
        logic [3:0]  exp_wr;
        logic        stall;
    } test_t;

    logic                          clk;
    logic                          rst_n_i;
    logic                          req_valid_i;
    logic                          req_ready_o;
    logic                          req_write_i;
    logic [dcache_pkg::ADDR_W-1:0] req_addr_i;
    logic [dcache_pkg::DATA_W-1:0] req_wdata_i;
    logic [dcache_pkg::STRB_W-1:0] req_strb_i;
    logic                          rsp_valid_o;
    logic                          rsp_ready_i;
    logic [dcache_pkg::DATA_W-1:0] rsp_rdata_o;
    logic                          mem_req_valid_o;
    logic                          mem_req_ready_i;
    logic                          mem_req_write_o;
    logic [dcache_pkg::ADDR_W-1:0] mem_req_addr_o;
    logic [dcache_pkg::DATA_W-1:0] mem_req_wdata_o;
    logic                          mem_rsp_valid_i;
    logic [dcache_pkg::DATA_W-1:0] mem_rsp_rdata_i;

    test_t       tests [$];
    logic [63:0] mem_words [logic [31:0]];
    logic [63:0] shadow_words [logic [31:0]];
    logic [15:0] lfsr_q;
    logic [31:0] req_line;
    int          errors = 0;
    int          mem_reads = 0;
    int          mem_writes = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    dcache_top u_dcache_top (.*);

    always #10 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = (v << 1) | {31'd0, lfsr_q[0]};
        end
        return v;
    endfunction

    // power-up memory contents
    function automatic logic [63:0] init_word(input logic [31:0] addr);
        logic [63:0] wide;
        wide = {32'd0, addr};
        return wide * 64'h0101_0101_0101_0101;
    endfunction

    function automatic logic [63:0] mem_word(input logic [31:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return init_word(addr);
    endfunction

    function automatic logic [63:0] shadow_word(input logic [31:0] addr);
        if (shadow_words.exists(addr)) begin
            return shadow_words[addr];
        end
        return init_word(addr);
    endfunction

    function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                                input logic [63:0] new_word,
                                                input logic [7:0]  strb);
        logic [63:0] res;
        for (int b = 0; b < 8; b++) begin
            res[b*8 +: 8] = strb[b] ? new_word[b*8 +: 8] : old_word[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        test_t       t;
        logic        op_v;
        logic [31:0] addr_v;
        logic [63:0] wdata_v;
        logic [7:0]  strb_v;
        logic [63:0] exp_v;
        logic [3:0]  rd_v;
        logic [3:0]  wr_v;
        logic        stall_v;
        fd = $fopen("sim/dcache_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file sim/dcache_tests.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // skip comment and blank lines
            if (line.len() > 1 && line.getc(0) != "/") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h", op_v, addr_v, wdata_v,
                            strb_v, exp_v, rd_v, wr_v, stall_v);
                if (n == 8) begin
                    t.write     = op_v;
                    t.addr      = addr_v;
                    t.wdata     = wdata_v;
                    t.strb      = strb_v;
                    t.exp_rdata = exp_v;
                    t.exp_rd    = rd_v;
                    t.exp_wr    = wr_v;
                    t.stall     = stall_v;
                    tests.push_back(t);
                end
            end
        end
        $fclose(fd);
    endtask

    // grant and answer one memory request after random delays
    task automatic serve_mem_request();
        logic        wr;
        logic [31:0] addr;
        logic [63:0] wdata;
        int unsigned delay;
        delay = rand_bits(2);
        repeat (delay) @(negedge clk);
        wr    = mem_req_write_o;
        addr  = mem_req_addr_o;
        wdata = mem_req_wdata_o;
        mem_req_ready_i = 1'b1;
        @(negedge clk);
        mem_req_ready_i = 1'b0;
        if (wr) begin
            mem_writes++;
            check_value("mem_req_wdata_o", wdata, shadow_word(addr));
            mem_words[addr] = wdata;
        end else begin
            mem_reads++;
            check_value("mem_req_addr_o", {32'd0, addr}, {32'd0, req_line});
            delay = rand_bits(2);
            repeat (delay) @(negedge clk);
            mem_rsp_rdata_i = mem_word(addr);
            mem_rsp_valid_i = 1'b1;
            @(negedge clk);
            mem_rsp_valid_i = 1'b0;
        end
    endtask

    task automatic run_request(input test_t t);
        int          edges;
        int unsigned hold;
        logic [31:0] line_addr;
        while (!req_ready_o) @(negedge clk);
        line_addr   = {t.addr[31:3], 3'b000};
        req_line    = line_addr;
        mem_reads   = 0;
        mem_writes  = 0;
        rsp_ready_i = !t.stall;
        req_valid_i = 1'b1;
        req_write_i = t.write;
        req_addr_i  = t.addr;
        req_wdata_i = t.wdata;
        req_strb_i  = t.strb;
        if (t.write) begin
            shadow_words[line_addr] = merge_bytes(shadow_word(line_addr), t.wdata, t.strb);
        end
        @(negedge clk);
        req_valid_i = 1'b0;
        edges = 1;
        while (!rsp_valid_o) begin
            @(negedge clk);
            edges++;
        end
        if (!t.write) begin
            check_value("rsp_rdata_o", rsp_rdata_o, t.exp_rdata);
        end
        check_value("mem_reads", 64'(mem_reads), 64'(t.exp_rd));
        check_value("mem_writes", 64'(mem_writes), 64'(t.exp_wr));
        // a hit answers on the third edge
        if (t.exp_rd == 4'd0 && t.exp_wr == 4'd0) begin
            check_value("rsp_valid_o latency", 64'(edges), 64'd3);
        end
        if (t.stall) begin
            hold = rand_bits(2) + 32'd1;
            repeat (hold) @(negedge clk);
            rsp_ready_i = 1'b1;
        end
        @(negedge clk);
    endtask

    initial begin : memory_model
        forever begin
            @(negedge clk);
            if (rst_n_i && mem_req_valid_o) begin
                serve_mem_request();
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the cache did not finish the tests in %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin : stimulus
        clk             = 1'b0;
        rst_n_i         = 1'b0;
        req_valid_i     = 1'b0;
        req_write_i     = 1'b0;
        req_addr_i      = '0;
        req_wdata_i     = '0;
        req_strb_i      = '0;
        rsp_ready_i     = 1'b1;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_rdata_i = '0;
        lfsr_q          = 16'd37775;
        load_tests();
        if (tests.size() == 0) begin
            $display("no tests were loaded from sim/dcache_tests.txt");
            errors++;
        end
        cycle_limit = 200 * tests.size() + 20;
        repeat (3) @(negedge clk);
        rst_n_i = 1'b1;
        foreach (tests[i]) begin
            run_request(tests[i]);
        end
        $display("%0d errors over %0d tests", errors, tests.size());
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- sim/dcache_tests.txt
// op addr wdata strb exp_rdata mem_reads mem_writes stall (hex, op 1 is a store)
// exp_rdata is compared for loads only, stall holds rsp_ready_i low for a while
0 00000040 0000000000000000 00 4040404040404040 1 0 0
0 00000044 0000000000000000 00 4040404040404040 0 0 0
1 00000040 1122334455667788 0f 0000000000000000 0 0 0
0 00000040 0000000000000000 00 4040404055667788 0 0 0
0 00000240 0000000000000000 00 4242424242424240 1 0 0
0 00000440 0000000000000000 00 4444444444444440 1 1 0
0 00000040 0000000000000000 00 4040404055667788 1 0 0
1 00000080 aabbccdd00000000 f0 0000000000000000 1 0 1
0 00000080 0000000000000000 00 aabbccdd80808080 0 0 1
1 00000280 0123456789abcdef ff 0000000000000000 1 0 1
0 00000480 0000000000000000 00 8484848484848480 1 1 1
0 00000680 0000000000000000 00 8686868686868680 1 1 1
0 00000280 0000000000000000 00 0123456789abcdef 1 0 1
0 00000080 0000000000000000 00 aabbccdd80808080 1 0 0
1 000000c0 ee000000000000ff 81 0000000000000000 1 0 1
0 000000c3 0000000000000000 00 eec0c0c0c0c0c0ff 0 0 0
0 00012340 0000000000000000 00 6464646464646340 1 0 0
0 00012344 0000000000000000 00 6464646464646340 0 0 1
